// File: logic/mmu_pkg.sv
/* sv32 mmu definitions */
`default_nettype none

package mmu_pkg;

    // ----------------------------------------------------------
    // address and page widths
    // ----------------------------------------------------------
    localparam int unsigned VLEN          = 32;
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPNW          = 22;
    localparam int unsigned VPNW          = 10;
    localparam int unsigned PAGE_OFFSET_W = 12;

    typedef logic [VLEN-1:0]   vaddr_t;
    typedef logic [PLEN-1:0]   paddr_t;
    typedef logic [PPNW-1:0]   ppn_t;
    typedef logic [2*VPNW-1:0] vpn_t;
    typedef logic [31:0]       pte_t;

    // ----------------------------------------------------------
    // page table entry layout
    // ----------------------------------------------------------
    localparam int unsigned PTE_V       = 0;
    localparam int unsigned PTE_R       = 1;
    localparam int unsigned PTE_W       = 2;
    localparam int unsigned PTE_X       = 3;
    localparam int unsigned PTE_U       = 4;
    localparam int unsigned PTE_A       = 6;
    localparam int unsigned PTE_D       = 7;
    // ppn[0] sits right above the flag and rsw bits
    localparam int unsigned PTE_PPN_LSB = 10;

    // ----------------------------------------------------------
    // privilege and exception causes
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1
    } priv_lvl_t;

    typedef logic [4:0] cause_t;

    localparam cause_t CAUSE_LOAD_PAGE_FAULT  = 5'd13;
    localparam cause_t CAUSE_STORE_PAGE_FAULT = 5'd15;

    // page table walker FSM
    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_WAIT_GNT,
        WALK_WAIT_DATA,
        WALK_ERROR
    } walker_state_t;

endpackage

`default_nettype wire

// File: logic/dtlb.sv
/* data TLB */
`timescale 1ns/1ps
`default_nettype none

module dtlb #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  mmu_pkg::vaddr_t lu_vaddr_i,
    input  logic            update_valid_i,
    input  mmu_pkg::vpn_t   update_vpn_i,
    input  mmu_pkg::pte_t   update_pte_i,
    input  logic            update_is_4m_i,
    output logic            lu_hit_o,
    output mmu_pkg::pte_t   lu_pte_o,
    output logic            lu_is_4m_o
);

    localparam int unsigned VPNW  = mmu_pkg::VPNW;
    localparam int unsigned IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] valid_q;
    logic [TLB_ENTRIES-1:0] is_4m_q;
    mmu_pkg::vpn_t          tag_q [TLB_ENTRIES];
    mmu_pkg::pte_t          pte_q [TLB_ENTRIES];
    logic [IDX_W-1:0]       rr_ptr_q;

    mmu_pkg::vpn_t          lu_vpn;
    logic [TLB_ENTRIES-1:0] match;

    assign lu_vpn = lu_vaddr_i[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W];

    // ----------------------------------------------------------
    // lookup
    // ----------------------------------------------------------
    // a megapage entry only compares vpn[1]
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (tag_q[i][VPNW +: VPNW] == lu_vpn[VPNW +: VPNW])
                && (is_4m_q[i] || (tag_q[i][VPNW-1:0] == lu_vpn[VPNW-1:0]));
        end
    end

    always_comb begin
        lu_hit_o   = |match;
        lu_pte_o   = '0;
        lu_is_4m_o = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                lu_pte_o   = pte_q[i];
                lu_is_4m_o = is_4m_q[i];
            end
        end
    end

    // ----------------------------------------------------------
    // refill and flush
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[rr_ptr_q] <= 1'b1;
            // round robin victim
            if (rr_ptr_q == IDX_W'(TLB_ENTRIES - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= rr_ptr_q + 1'b1;
            end
        end
    end

    // entry contents
    always_ff @(posedge clk_i) begin
        if (update_valid_i && !flush_i) begin
            tag_q[rr_ptr_q]   <= update_vpn_i;
            pte_q[rr_ptr_q]   <= update_pte_i;
            is_4m_q[rr_ptr_q] <= update_is_4m_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/page_walker.sv
/* two-level page table walker */
`timescale 1ns/1ps
`default_nettype none

module page_walker (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            walk_req_i,
    input  mmu_pkg::vaddr_t walk_vaddr_i,
    input  mmu_pkg::ppn_t   satp_ppn_i,
    output logic            mem_req_o,
    output mmu_pkg::paddr_t mem_addr_o,
    input  logic            mem_gnt_i,
    input  logic            mem_rvalid_i,
    input  mmu_pkg::pte_t   mem_rdata_i,
    output logic            update_valid_o,
    output mmu_pkg::vpn_t   update_vpn_o,
    output mmu_pkg::pte_t   update_pte_o,
    output logic            update_is_4m_o,
    output logic            walk_active_o,
    output logic            walk_error_o,
    output logic            miss_pulse_o
);

    localparam int unsigned VPNW    = mmu_pkg::VPNW;
    localparam int unsigned OFFW    = mmu_pkg::PAGE_OFFSET_W;
    localparam int unsigned PPN_LSB = mmu_pkg::PTE_PPN_LSB;

    mmu_pkg::walker_state_t state_q, state_d;
    // high while reading the root table
    logic                   level_q, level_d;
    mmu_pkg::vaddr_t        vaddr_q, vaddr_d;
    mmu_pkg::paddr_t        addr_q, addr_d;

    logic pte_leaf;
    logic pte_bad;
    logic pte_misaligned;

    // ----------------------------------------------------------
    // pte decode
    // ----------------------------------------------------------
    assign pte_leaf = mem_rdata_i[mmu_pkg::PTE_R] | mem_rdata_i[mmu_pkg::PTE_X];
    assign pte_bad  = !mem_rdata_i[mmu_pkg::PTE_V]
                   || (mem_rdata_i[mmu_pkg::PTE_W] && !mem_rdata_i[mmu_pkg::PTE_R]);
    // megapage must be 4 MiB aligned
    assign pte_misaligned = level_q && (mem_rdata_i[PPN_LSB +: VPNW] != '0);

    assign mem_req_o     = (state_q == mmu_pkg::WALK_WAIT_GNT);
    assign mem_addr_o    = addr_q;
    assign walk_active_o = (state_q != mmu_pkg::WALK_IDLE);
    assign walk_error_o  = (state_q == mmu_pkg::WALK_ERROR);
    assign miss_pulse_o  = (state_q == mmu_pkg::WALK_IDLE) && walk_req_i;

    assign update_vpn_o   = vaddr_q[mmu_pkg::VLEN-1:OFFW];
    assign update_pte_o   = mem_rdata_i;
    assign update_is_4m_o = level_q;

    // ----------------------------------------------------------
    // walk FSM
    // ----------------------------------------------------------
    always_comb begin
        state_d        = state_q;
        level_d        = level_q;
        vaddr_d        = vaddr_q;
        addr_d         = addr_q;
        update_valid_o = 1'b0;

        case (state_q)
            mmu_pkg::WALK_IDLE: begin
                if (walk_req_i) begin
                    vaddr_d = walk_vaddr_i;
                    level_d = 1'b1;
                    addr_d  = {satp_ppn_i, walk_vaddr_i[OFFW+VPNW +: VPNW], 2'b00};
                    state_d = mmu_pkg::WALK_WAIT_GNT;
                end
            end
            mmu_pkg::WALK_WAIT_GNT: begin
                if (mem_gnt_i) begin
                    state_d = mmu_pkg::WALK_WAIT_DATA;
                end
            end
            mmu_pkg::WALK_WAIT_DATA: begin
                if (mem_rvalid_i) begin
                    if (pte_bad) begin
                        state_d = mmu_pkg::WALK_ERROR;
                    end else if (pte_leaf) begin
                        if (pte_misaligned) begin
                            state_d = mmu_pkg::WALK_ERROR;
                        end else begin
                            update_valid_o = 1'b1;
                            state_d        = mmu_pkg::WALK_IDLE;
                        end
                    end else if (level_q) begin
                        // pointer to the second level table
                        level_d = 1'b0;
                        addr_d  = {mem_rdata_i[PPN_LSB +: mmu_pkg::PPNW],
                                   vaddr_q[OFFW +: VPNW], 2'b00};
                        state_d = mmu_pkg::WALK_WAIT_GNT;
                    end else begin
                        state_d = mmu_pkg::WALK_ERROR;
                    end
                end
            end
            default: begin
                state_d = mmu_pkg::WALK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= mmu_pkg::WALK_IDLE;
            level_q <= 1'b0;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
        addr_q  <= addr_d;
    end

endmodule

`default_nettype wire

// File: logic/lsu_translate.sv
/* load/store translation stage */
`timescale 1ns/1ps
`default_nettype none

module lsu_translate (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               lsu_req_i,
    input  mmu_pkg::vaddr_t    lsu_vaddr_i,
    input  logic               lsu_is_store_i,
    input  logic               en_translation_i,
    input  mmu_pkg::priv_lvl_t priv_lvl_i,
    input  logic               sum_i,
    input  logic               lu_hit_i,
    input  mmu_pkg::pte_t      lu_pte_i,
    input  logic               lu_is_4m_i,
    input  logic               walk_active_i,
    input  logic               walk_error_i,
    output logic               walk_req_o,
    output mmu_pkg::vaddr_t    walk_vaddr_o,
    output logic               lsu_dtlb_hit_o,
    output mmu_pkg::ppn_t      lsu_dtlb_ppn_o,
    output logic               lsu_valid_o,
    output mmu_pkg::paddr_t    lsu_paddr_o,
    output logic               lsu_ex_valid_o,
    output mmu_pkg::cause_t    lsu_ex_cause_o,
    output mmu_pkg::vaddr_t    lsu_ex_tval_o
);

    localparam int unsigned VPNW = mmu_pkg::VPNW;
    localparam int unsigned OFFW = mmu_pkg::PAGE_OFFSET_W;

    logic            req_q;
    logic            hit_q;
    logic            err_q;
    logic            store_q;
    logic            is_4m_q;
    mmu_pkg::vaddr_t vaddr_q;
    mmu_pkg::pte_t   pte_q;

    mmu_pkg::ppn_t   ppn_q;
    logic            priv_err;
    logic            perm_err;

    // pte ppn, where a megapage takes ppn[0] from vpn[0]
    function automatic mmu_pkg::ppn_t page_ppn(input mmu_pkg::pte_t pte, input logic is_4m,
                                               input mmu_pkg::vaddr_t va);
        mmu_pkg::ppn_t ppn;
        ppn = pte[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW];
        if (is_4m) begin
            ppn[VPNW-1:0] = va[OFFW +: VPNW];
        end
        return ppn;
    endfunction

    // ----------------------------------------------------------
    // request cycle
    // ----------------------------------------------------------
    // no new walk while the error of the last one is answered
    assign walk_req_o     = lsu_req_i && en_translation_i && !lu_hit_i && !err_q;
    assign walk_vaddr_o   = lsu_vaddr_i;
    assign lsu_dtlb_hit_o = en_translation_i ? lu_hit_i : 1'b1;
    assign lsu_dtlb_ppn_o = en_translation_i ? page_ppn(lu_pte_i, lu_is_4m_i, lsu_vaddr_i)
                                             : mmu_pkg::ppn_t'(lsu_vaddr_i[mmu_pkg::VLEN-1:OFFW]);

    // ----------------------------------------------------------
    // response cycle
    // ----------------------------------------------------------
    assign ppn_q = page_ppn(pte_q, is_4m_q, vaddr_q);

    assign priv_err = ((priv_lvl_i == mmu_pkg::PRIV_S) && !sum_i && pte_q[mmu_pkg::PTE_U])
                   || ((priv_lvl_i == mmu_pkg::PRIV_U) && !pte_q[mmu_pkg::PTE_U]);
    // stores need W and D, loads need R
    assign perm_err = store_q ? (!pte_q[mmu_pkg::PTE_W] || !pte_q[mmu_pkg::PTE_D])
                              : !pte_q[mmu_pkg::PTE_R];

    always_comb begin
        lsu_valid_o    = req_q;
        lsu_paddr_o    = mmu_pkg::paddr_t'(vaddr_q);
        lsu_ex_valid_o = 1'b0;
        if (en_translation_i) begin
            lsu_valid_o    = req_q && (hit_q || err_q);
            lsu_paddr_o    = {ppn_q, vaddr_q[OFFW-1:0]};
            lsu_ex_valid_o = req_q && (err_q || (hit_q && (priv_err || perm_err)));
        end
    end

    assign lsu_ex_cause_o = store_q ? mmu_pkg::CAUSE_STORE_PAGE_FAULT
                                    : mmu_pkg::CAUSE_LOAD_PAGE_FAULT;
    assign lsu_ex_tval_o  = vaddr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= lu_hit_i;
            err_q <= walk_error_i && walk_active_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= lsu_vaddr_i;
        store_q <= lsu_is_store_i;
        pte_q   <= lu_pte_i;
        is_4m_q <= lu_is_4m_i;
    end

endmodule

`default_nettype wire

// File: logic/mmu_top.sv
/* load/store mmu */
`timescale 1ns/1ps
`default_nettype none

module mmu_top #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // lsu request
    input  logic               lsu_req_i,
    input  mmu_pkg::vaddr_t    lsu_vaddr_i,
    input  logic               lsu_is_store_i,
    output logic               lsu_dtlb_hit_o,
    output mmu_pkg::ppn_t      lsu_dtlb_ppn_o,
    output logic               lsu_valid_o,
    output mmu_pkg::paddr_t    lsu_paddr_o,
    output logic               lsu_ex_valid_o,
    output mmu_pkg::cause_t    lsu_ex_cause_o,
    output mmu_pkg::vaddr_t    lsu_ex_tval_o,
    // csr state
    input  logic               en_translation_i,
    input  mmu_pkg::priv_lvl_t priv_lvl_i,
    input  logic               sum_i,
    input  mmu_pkg::ppn_t      satp_ppn_i,
    input  logic               flush_tlb_i,
    output logic               dtlb_miss_o,
    // page table memory
    output logic               mem_req_o,
    output mmu_pkg::paddr_t    mem_addr_o,
    input  logic               mem_gnt_i,
    input  logic               mem_rvalid_i,
    input  mmu_pkg::pte_t      mem_rdata_i
);

    logic            walk_req;
    mmu_pkg::vaddr_t walk_vaddr;
    logic            walk_active;
    logic            walk_error;
    logic            update_valid;
    mmu_pkg::vpn_t   update_vpn;
    mmu_pkg::pte_t   update_pte;
    logic            update_is_4m;
    logic            lu_hit;
    mmu_pkg::pte_t   lu_pte;
    logic            lu_is_4m;

    dtlb #(
        .TLB_ENTRIES    (TLB_ENTRIES)
    ) u_dtlb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_tlb_i),
        .lu_vaddr_i     (lsu_vaddr_i),
        .update_valid_i (update_valid),
        .update_vpn_i   (update_vpn),
        .update_pte_i   (update_pte),
        .update_is_4m_i (update_is_4m),
        .lu_hit_o       (lu_hit),
        .lu_pte_o       (lu_pte),
        .lu_is_4m_o     (lu_is_4m)
    );

    page_walker u_walker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .walk_req_i     (walk_req),
        .walk_vaddr_i   (walk_vaddr),
        .satp_ppn_i     (satp_ppn_i),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_gnt_i      (mem_gnt_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .update_valid_o (update_valid),
        .update_vpn_o   (update_vpn),
        .update_pte_o   (update_pte),
        .update_is_4m_o (update_is_4m),
        .walk_active_o  (walk_active),
        .walk_error_o   (walk_error),
        .miss_pulse_o   (dtlb_miss_o)
    );

    lsu_translate u_translate (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .lsu_req_i        (lsu_req_i),
        .lsu_vaddr_i      (lsu_vaddr_i),
        .lsu_is_store_i   (lsu_is_store_i),
        .en_translation_i (en_translation_i),
        .priv_lvl_i       (priv_lvl_i),
        .sum_i            (sum_i),
        .lu_hit_i         (lu_hit),
        .lu_pte_i         (lu_pte),
        .lu_is_4m_i       (lu_is_4m),
        .walk_active_i    (walk_active),
        .walk_error_i     (walk_error),
        .walk_req_o       (walk_req),
        .walk_vaddr_o     (walk_vaddr),
        .lsu_dtlb_hit_o   (lsu_dtlb_hit_o),
        .lsu_dtlb_ppn_o   (lsu_dtlb_ppn_o),
        .lsu_valid_o      (lsu_valid_o),
        .lsu_paddr_o      (lsu_paddr_o),
        .lsu_ex_valid_o   (lsu_ex_valid_o),
        .lsu_ex_cause_o   (lsu_ex_cause_o),
        .lsu_ex_tval_o    (lsu_ex_tval_o)
    );

endmodule

`default_nettype wire

// File: sim/mmu_assertions.sv
/* mmu protocol checks */
`timescale 1ns/1ps
`default_nettype none

module mmu_assertions (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            lsu_req_i,
    input  logic            lsu_valid_i,
    input  logic            lsu_ex_valid_i,
    input  logic            mem_req_i,
    input  mmu_pkg::paddr_t mem_addr_i,
    input  logic            mem_gnt_i
);

    // failures seen so far, read by the testbench at the end of each test
    int unsigned fail_cnt = 0;

    // ----------------------------------------------------------
    // memory port
    // ----------------------------------------------------------
    // request and address stay put until the grant
    a_mem_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i))
        else begin
            $error("mem_req_o dropped or mem_addr_o moved before mem_gnt_i");
            fail_cnt++;
        end

    // walker comes out of reset idle
    a_reset_idle : assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !mem_req_i && !lsu_valid_i)
        else begin
            $error("mem_req_o or lsu_valid_o high right after reset");
            fail_cnt++;
        end

    // ----------------------------------------------------------
    // lsu response
    // ----------------------------------------------------------
    a_valid_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_i |-> $past(lsu_req_i))
        else begin
            $error("lsu_valid_o without a request in the previous cycle");
            fail_cnt++;
        end

    a_ex_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_ex_valid_i |-> lsu_valid_i)
        else begin
            $error("lsu_ex_valid_o raised while lsu_valid_o is low");
            fail_cnt++;
        end

endmodule

bind mmu_top mmu_assertions u_assertions (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .lsu_valid_i    (lsu_valid_o),
    .lsu_ex_valid_i (lsu_ex_valid_o),
    .mem_req_i      (mem_req_o),
    .mem_addr_i     (mem_addr_o),
    .mem_gnt_i      (mem_gnt_i)
);

`default_nettype wire

// File: sim/tb_mmu.sv
/* mmu testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_mmu;

    // about 20 accesses of up to ~15 cycles each, with a wide margin
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    localparam mmu_pkg::ppn_t ROOT_PPN = 22'h00100;
    localparam mmu_pkg::ppn_t L0_PPN   = 22'h00200;
    localparam mmu_pkg::ppn_t PAGE_PPN = 22'h12345;
    localparam mmu_pkg::ppn_t MEGA_PPN = 22'h00c00;
    localparam mmu_pkg::cause_t LOAD_FAULT  = 5'd13;
    localparam mmu_pkg::cause_t STORE_FAULT = 5'd15;

    // pte flag byte
    localparam logic [7:0] FLAG_V = 8'h01;
    localparam logic [7:0] FLAG_R = 8'h02;
    localparam logic [7:0] FLAG_W = 8'h04;
    localparam logic [7:0] FLAG_U = 8'h10;
    localparam logic [7:0] FLAG_A = 8'h40;
    localparam logic [7:0] FLAG_D = 8'h80;
    localparam logic [7:0] RWAD   = FLAG_V | FLAG_R | FLAG_W | FLAG_A | FLAG_D;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic lsu_req = 1'b0;
    mmu_pkg::vaddr_t lsu_vaddr = '0;
    logic lsu_is_store = 1'b0;
    logic en_translation = 1'b0;
    mmu_pkg::priv_lvl_t priv_lvl = mmu_pkg::PRIV_S;
    logic sum = 1'b0;
    logic flush_tlb = 1'b0;
    logic mem_gnt = 1'b0;
    logic mem_rvalid = 1'b0;
    mmu_pkg::pte_t mem_rdata = '0;

    logic lsu_dtlb_hit;
    mmu_pkg::ppn_t lsu_dtlb_ppn;
    logic lsu_valid;
    mmu_pkg::paddr_t lsu_paddr;
    logic lsu_ex_valid;
    mmu_pkg::cause_t lsu_ex_cause;
    mmu_pkg::vaddr_t lsu_ex_tval;
    logic dtlb_miss;
    logic mem_req;
    mmu_pkg::paddr_t mem_addr;

    mmu_pkg::pte_t pt_mem [mmu_pkg::paddr_t];
    int seed = 8;
    int gnt_delay = 0;
    int unsigned cycle_cnt = 0;
    int errors = 0;
    int start_errors = 0;
    int unsigned start_asserts = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // results of the last access
    logic res_hit0;
    mmu_pkg::ppn_t res_ppn0;
    logic res_ex;
    mmu_pkg::paddr_t res_paddr;
    mmu_pkg::cause_t res_cause;
    mmu_pkg::vaddr_t res_tval;
    int res_cycles;
    int res_misses;

    mmu_top #(
        .TLB_ENTRIES      (4)
    ) u_dut (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .lsu_req_i        (lsu_req),
        .lsu_vaddr_i      (lsu_vaddr),
        .lsu_is_store_i   (lsu_is_store),
        .lsu_dtlb_hit_o   (lsu_dtlb_hit),
        .lsu_dtlb_ppn_o   (lsu_dtlb_ppn),
        .lsu_valid_o      (lsu_valid),
        .lsu_paddr_o      (lsu_paddr),
        .lsu_ex_valid_o   (lsu_ex_valid),
        .lsu_ex_cause_o   (lsu_ex_cause),
        .lsu_ex_tval_o    (lsu_ex_tval),
        .en_translation_i (en_translation),
        .priv_lvl_i       (priv_lvl),
        .sum_i            (sum),
        .satp_ppn_i       (ROOT_PPN),
        .flush_tlb_i      (flush_tlb),
        .dtlb_miss_o      (dtlb_miss),
        .mem_req_o        (mem_req),
        .mem_addr_o       (mem_addr),
        .mem_gnt_i        (mem_gnt),
        .mem_rvalid_i     (mem_rvalid),
        .mem_rdata_i      (mem_rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // page table memory model
    // ----------------------------------------------------------
    function automatic mmu_pkg::pte_t read_pte(input mmu_pkg::paddr_t addr);
        if (pt_mem.exists(addr)) begin
            return pt_mem[addr];
        end
        return '0;
    endfunction

    // grant after 0 to 2 cycles, data one cycle after the grant
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_gnt    <= 1'b0;
            mem_rvalid <= 1'b0;
            mem_rdata  <= '0;
            gnt_delay  <= 0;
        end else begin
            mem_gnt    <= 1'b0;
            mem_rvalid <= 1'b0;
            if (mem_req && mem_gnt) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= read_pte(mem_addr);
            end else if (mem_req) begin
                if (gnt_delay == 0) begin
                    mem_gnt <= 1'b1;
                end else begin
                    gnt_delay <= gnt_delay - 1;
                end
            end else begin
                gnt_delay <= $unsigned($random(seed)) % 3;
            end
        end
    end

    function automatic mmu_pkg::pte_t make_pte(input mmu_pkg::ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // table base times the page size, plus four bytes per entry
    function automatic mmu_pkg::paddr_t pte_slot(input mmu_pkg::ppn_t base, input logic [9:0] vpn);
        return (mmu_pkg::paddr_t'(base) << 12) + (mmu_pkg::paddr_t'(vpn) << 2);
    endfunction

    function automatic mmu_pkg::paddr_t exp_paddr(input mmu_pkg::ppn_t ppn,
                                                  input mmu_pkg::vaddr_t va, input logic mega);
        mmu_pkg::ppn_t p;
        p = ppn;
        if (mega) begin
            p[9:0] = va[21:12];
        end
        return (mmu_pkg::paddr_t'(p) << 12) | mmu_pkg::paddr_t'(va[11:0]);
    endfunction

    // ----------------------------------------------------------
    // stimulus and checks
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic set_mode(input logic en, input mmu_pkg::priv_lvl_t priv, input logic s);
        @(posedge clk);
        en_translation <= en;
        priv_lvl       <= priv;
        sum            <= s;
    endtask

    // issue one request and hold it until lsu_valid_o
    task automatic access(input mmu_pkg::vaddr_t va, input logic store);
        @(posedge clk);
        lsu_req      <= 1'b1;
        lsu_vaddr    <= va;
        lsu_is_store <= store;
        @(negedge clk);
        res_hit0   = lsu_dtlb_hit;
        res_ppn0   = lsu_dtlb_ppn;
        res_misses = dtlb_miss ? 1 : 0;
        res_cycles = 0;
        do begin
            @(negedge clk);
            res_cycles++;
            if (dtlb_miss) begin
                res_misses++;
            end
        end while (!lsu_valid);
        res_ex    = lsu_ex_valid;
        res_paddr = lsu_paddr;
        res_cause = lsu_ex_cause;
        res_tval  = lsu_ex_tval;
        @(posedge clk);
        lsu_req <= 1'b0;
    endtask

    task automatic expect_paddr(input mmu_pkg::paddr_t paddr);
        check_value("lsu_ex_valid_o", 64'(1'b0), 64'(res_ex));
        check_value("lsu_paddr_o", 64'(paddr), 64'(res_paddr));
    endtask

    task automatic expect_fault(input mmu_pkg::vaddr_t va, input mmu_pkg::cause_t cause);
        check_value("lsu_ex_valid_o", 64'(1'b1), 64'(res_ex));
        check_value("lsu_ex_cause_o", 64'(cause), 64'(res_cause));
        check_value("lsu_ex_tval_o", 64'(va), 64'(res_tval));
    endtask

    task automatic expect_hit(input mmu_pkg::ppn_t ppn);
        check_value("lsu_dtlb_hit_o", 64'(1'b1), 64'(res_hit0));
        check_value("lsu_dtlb_ppn_o", 64'(ppn), 64'(res_ppn0));
        check_value("response latency", 64'(1), 64'(res_cycles));
        check_value("dtlb_miss_o pulses", 64'(0), 64'(res_misses));
    endtask

    task automatic expect_miss();
        check_value("lsu_dtlb_hit_o", 64'(1'b0), 64'(res_hit0));
        check_value("dtlb_miss_o pulses", 64'(1), 64'(res_misses));
    endtask

    task automatic begin_test();
        start_errors  = errors;
        start_asserts = u_dut.u_assertions.fail_cnt;
    endtask

    task automatic report_test(input string name);
        @(negedge clk);
        if (errors == start_errors && u_dut.u_assertions.fail_cnt == start_asserts) begin
            $display("PASS  %s", name);
            tests_passed++;
        end else begin
            $display("FAIL  %s", name);
            tests_failed++;
        end
    endtask

    initial begin
        pt_mem[pte_slot(ROOT_PPN, 10'd1)] = make_pte(L0_PPN, FLAG_V);
        pt_mem[pte_slot(L0_PPN, 10'd0)]   = make_pte(PAGE_PPN, RWAD);
        pt_mem[pte_slot(L0_PPN, 10'd1)]   = make_pte(22'h00777, RWAD & ~FLAG_W);
        pt_mem[pte_slot(L0_PPN, 10'd2)]   = make_pte(22'h00778, RWAD & ~FLAG_D);
        pt_mem[pte_slot(L0_PPN, 10'd3)]   = make_pte(22'h00779, RWAD | FLAG_U);
        // vpn[0] = 4 stays empty and reads as an invalid pte
        pt_mem[pte_slot(ROOT_PPN, 10'd2)] = make_pte(MEGA_PPN, RWAD);
        pt_mem[pte_slot(ROOT_PPN, 10'd3)] = make_pte(MEGA_PPN | 22'h1, RWAD);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        set_mode(1'b0, mmu_pkg::PRIV_S, 1'b0);
        access(32'h1234_5678, 1'b0);
        expect_hit(22'h12345);
        expect_paddr({2'b00, 32'h1234_5678});
        access(32'hffff_f004, 1'b1);
        expect_hit(22'hfffff);
        expect_paddr({2'b00, 32'hffff_f004});
        report_test("translation off");

        begin_test();
        set_mode(1'b1, mmu_pkg::PRIV_S, 1'b0);
        access(32'h0040_0abc, 1'b1);
        expect_miss();
        expect_paddr(exp_paddr(PAGE_PPN, 32'h0040_0abc, 1'b0));
        access(32'h0040_0123, 1'b0);
        expect_hit(PAGE_PPN);
        expect_paddr(exp_paddr(PAGE_PPN, 32'h0040_0123, 1'b0));
        report_test("4 KiB page walk and TLB hit");

        begin_test();
        access(32'h0080_5123, 1'b0);
        expect_miss();
        expect_paddr(exp_paddr(MEGA_PPN, 32'h0080_5123, 1'b1));
        access(32'h0080_7ffc, 1'b1);
        expect_hit(MEGA_PPN | 22'h7);
        expect_paddr(exp_paddr(MEGA_PPN, 32'h0080_7ffc, 1'b1));
        report_test("megapage");

        begin_test();
        access(32'h0040_1010, 1'b1);
        expect_fault(32'h0040_1010, STORE_FAULT);
        access(32'h0040_2020, 1'b1);
        expect_fault(32'h0040_2020, STORE_FAULT);
        access(32'h0040_3030, 1'b0);
        expect_fault(32'h0040_3030, LOAD_FAULT);
        set_mode(1'b1, mmu_pkg::PRIV_S, 1'b1);
        access(32'h0040_3034, 1'b0);
        expect_paddr(exp_paddr(22'h00779, 32'h0040_3034, 1'b0));
        set_mode(1'b1, mmu_pkg::PRIV_U, 1'b0);
        access(32'h0040_0040, 1'b0);
        expect_fault(32'h0040_0040, LOAD_FAULT);
        report_test("permission faults");

        begin_test();
        set_mode(1'b1, mmu_pkg::PRIV_S, 1'b0);
        access(32'h0040_4000, 1'b0);
        expect_miss();
        expect_fault(32'h0040_4000, LOAD_FAULT);
        access(32'h00c0_0100, 1'b1);
        expect_miss();
        expect_fault(32'h00c0_0100, STORE_FAULT);
        report_test("walk faults");

        begin_test();
        access(32'h0040_0abc, 1'b0);
        expect_hit(PAGE_PPN);
        @(posedge clk);
        flush_tlb <= 1'b1;
        @(posedge clk);
        flush_tlb <= 1'b0;
        access(32'h0040_0abc, 1'b0);
        expect_miss();
        expect_paddr(exp_paddr(PAGE_PPN, 32'h0040_0abc, 1'b0));
        report_test("TLB flush");

        $display("tests passed: %0d  failed: %0d  assertion failures: %0d",
                 tests_passed, tests_failed, u_dut.u_assertions.fail_cnt);
        if (tests_failed == 0 && u_dut.u_assertions.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/mmu_pkg.sv
logic/dtlb.sv
logic/page_walker.sv
logic/lsu_translate.sv
logic/mmu_top.sv
sim/mmu_assertions.sv
sim/tb_mmu.sv

// File: run.sh
#!/usr/bin/env bash
# build the MMU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_mmu -Mdir obj_dir -o tb_mmu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mmu +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
